//--- src/cpuPkg.sv
// sizes, word type, instruction and select enums, control and memory structs
package cpuPkg;

	localparam int wordW    = 16;
	localparam int regAddrW = 3;
	localparam int nRegs    = 8;

	typedef logic [wordW-1:0] wordT;

	localparam wordT resetPc = 16'h0000; // first fetch address

	// IR[15:11]
	typedef enum logic [4:0] {
		opAdd  = 5'd0,
		opSub  = 5'd1,
		opAnd  = 5'd2,
		opOr   = 5'd3,
		opXor  = 5'd4,
		opAddi = 5'd5,
		opLdi  = 5'd6,
		opLdw  = 5'd7,
		opStw  = 5'd8,
		opBr   = 5'd9,
		opBeq  = 5'd10,
		opBl   = 5'd11,
		opRet  = 5'd12,
		opHalt = 5'd31
	} opcodeT;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPassB} aluFuncT;

	typedef enum logic [1:0] {busMem, busAluOut, busLr} busSelT;
	typedef enum logic [1:0] {pcInc, pcAlu, pcLr} pcSelT;
	typedef enum logic {op1Rd1, op1Pc} op1SelT;
	typedef enum logic [1:0] {op2Rd2, op2ImmShort, op2ImmLong, op2Zero} op2SelT;
	typedef enum logic [1:0] {rwRd, rwRa, rwSeven} rwSelT;
	typedef enum logic {wdBus, wdAlu} wdSelT;

	typedef enum logic [2:0] {
		stFetch,
		stDecode,
		stExecute,
		stMemory,
		stWriteback,
		stHalted
	} stateT;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} flagsT;

	// everything the controller steers in the datapath
	typedef struct packed {
		busSelT  busSel;
		pcSelT   pcSel;
		op1SelT  op1Sel;
		op2SelT  op2Sel;
		rwSelT   rwSel;  // also picks read port 1 source
		wdSelT   wdSel;
		aluFuncT aluFunc;
		logic    pcWe;
		logic    irWe;
		logic    lrWe;
		logic    aluOutWe;
		logic    regWe;
		logic    flagsWe;
	} dpCtrlT;

	typedef struct packed {
		opcodeT opcode;
		flagsT  flags;   // stored flags, not the live ALU ones
	} dpStatusT;

	typedef struct packed {
		logic we;
		wordT addr;
		wordT wdata;
	} memReqT;

endpackage

//--- src/regBlock.sv
// register file, eight words, two asynchronous reads and one synchronous write
`timescale 1ns/10ps

module regBlock import cpuPkg::*; (
	input  logic                Clock,
	input  logic                reset,
	input  logic [regAddrW-1:0] rs1,
	input  logic [regAddrW-1:0] rs2,
	input  logic [regAddrW-1:0] rw,
	input  logic                we,
	input  wordT                wData,
	output wordT                rd1,
	output wordT                rd2
);

	wordT regs [nRegs];

	always_ff @(posedge Clock) begin
		if (reset) begin
			for (int i = 0; i < nRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	// read ports see the old value during a write cycle
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

//--- src/alu.sv
// combinational ALU with zero, negative, carry and overflow flags
`timescale 1ns/10ps

module alu import cpuPkg::*; (
	input  wordT    op1,
	input  wordT    op2,
	input  aluFuncT func,
	output wordT    result,
	output flagsT   flags
);

	logic           isSub;
	logic           arith;
	wordT           op2Eff;
	logic [wordW:0] sum;   // one extra bit for carry out

	assign isSub = (func == aluSub);
	assign arith = (func == aluAdd) || isSub;

	// sub as op1 + ~op2 + 1, carry out high means no borrow
	assign op2Eff = isSub ? ~op2 : op2;
	assign sum    = {1'b0, op1} + {1'b0, op2Eff} + {{wordW{1'b0}}, isSub};

	always_comb begin
		case (func)
			aluAdd:   result = sum[wordW-1:0];
			aluSub:   result = sum[wordW-1:0];
			aluAnd:   result = op1 & op2;
			aluOr:    result = op1 | op2;
			aluXor:   result = op1 ^ op2;
			aluPassB: result = op2;
			default:  result = op2;
		endcase
	end

	assign flags.zero     = (result == '0);
	assign flags.negative = result[wordW-1];

	// carry and overflow only mean something for add and sub
	assign flags.carry    = arith & sum[wordW];
	assign flags.overflow = arith & (op1[wordW-1] == op2Eff[wordW-1]) &
		(sum[wordW-1] != op1[wordW-1]);

endmodule

//--- src/datapath.sv
// datapath with internal bus, operand and address muxes, PC, LR, IR, AluOut and flags
`timescale 1ns/10ps

module datapath import cpuPkg::*; (
	input  logic     Clock,
	input  logic     reset,
	input  dpCtrlT   ctrl,
	input  wordT     memRData,
	output dpStatusT status,
	output memReqT   memReqData
);

	wordT pc;
	wordT lr;
	wordT ir;
	wordT aluOut;
	wordT pcNext;
	wordT bus;
	wordT op1;
	wordT op2;
	wordT aluResult;
	wordT rd1;
	wordT rd2;
	wordT wData;
	wordT immShort;
	wordT immLong;

	flagsT flags;
	flagsT aluFlags;

	logic [regAddrW-1:0] fieldRd;
	logic [regAddrW-1:0] fieldRa;
	logic [regAddrW-1:0] fieldRb;
	logic [regAddrW-1:0] rs1;
	logic [regAddrW-1:0] rs2;
	logic [regAddrW-1:0] rw;

	logic fetchAddr;
	logic memStep;

	assign fieldRd = ir[10:8];
	assign fieldRa = ir[7:5];
	assign fieldRb = ir[4:2];

	assign immShort = {{(wordW-5){ir[4]}}, ir[4:0]};
	assign immLong  = {{(wordW-8){ir[7]}}, ir[7:0]};

	// PC on the ALU means fetch, so the address follows it
	assign fetchAddr = (ctrl.op1Sel == op1Pc);
	assign memStep   = (ctrl.busSel == busMem) && !fetchAddr;

	assign rs1 = (ctrl.rwSel == rwRd) ? fieldRd : fieldRa;
	assign rs2 = memStep ? fieldRd : fieldRb; // store data in memory steps

	always_comb begin
		case (ctrl.rwSel)
			rwRd:    rw = fieldRd;
			rwRa:    rw = fieldRa;
			default: rw = 3'd7;
		endcase
	end

	// muxed internal bus
	always_comb begin
		case (ctrl.busSel)
			busMem:    bus = memRData;
			busAluOut: bus = aluOut;
			default:   bus = lr;
		endcase
	end

	assign op1 = (ctrl.op1Sel == op1Pc) ? pc : rd1;

	always_comb begin
		case (ctrl.op2Sel)
			op2Rd2:      op2 = rd2;
			op2ImmShort: op2 = immShort;
			op2ImmLong:  op2 = immLong;
			default:     op2 = '0;
		endcase
	end

	assign wData = (ctrl.wdSel == wdBus) ? bus : aluResult;

	always_comb begin
		case (ctrl.pcSel)
			pcInc:   pcNext = pc + wordW'(1);
			pcAlu:   pcNext = aluResult;
			default: pcNext = lr;
		endcase
	end

	regBlock i_regBlock (
		.Clock (Clock),
		.reset (reset),
		.rs1   (rs1),
		.rs2   (rs2),
		.rw    (rw),
		.we    (ctrl.regWe),
		.wData (wData),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu i_alu (
		.op1    (op1),
		.op2    (op2),
		.func   (ctrl.aluFunc),
		.result (aluResult),
		.flags  (aluFlags)
	);

	always_ff @(posedge Clock) begin
		if (reset) begin
			pc    <= resetPc;
			ir    <= '0;
			flags <= '0;
		end else begin
			if (ctrl.pcWe) pc <= pcNext;
			if (ctrl.irWe) ir <= bus;
			if (ctrl.flagsWe) flags <= aluFlags;
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.lrWe) lr <= pc; // pc already points past the BL
		if (ctrl.aluOutWe) aluOut <= aluResult;
	end

	assign status.opcode = opcodeT'(ir[15:11]);
	assign status.flags  = flags;

	assign memReqData.we    = (status.opcode == opStw) && memStep;
	assign memReqData.addr  = fetchAddr ? pc : aluOut;
	assign memReqData.wdata = rd2;

endmodule

//--- src/controller.sv
// instruction FSM, opcode decode and four-phase memory handshake
`timescale 1ns/10ps

module controller import cpuPkg::*; (
	input  logic     Clock,
	input  logic     reset,
	input  dpStatusT status,
	input  logic     memAck,
	output dpCtrlT   ctrl,
	output logic     memReq,
	output logic     memWe,
	output logic     halted
);

	stateT   state;
	stateT   nextState;
	opcodeT  opcode;
	aluFuncT aluFunc;
	op2SelT  op2Sel;

	logic setsFlags;
	logic writesRd;
	logic legalOp;
	logic isLoad;
	logic isStore;
	logic isJump;
	logic takeJump;
	logic memDone;
	logic memStart;

	assign opcode = status.opcode;

	// opcode to ALU function and operand
	always_comb begin
		aluFunc   = aluAdd;
		op2Sel    = op2Rd2;
		setsFlags = 1'b0;
		writesRd  = 1'b0;
		legalOp   = 1'b1;
		case (opcode)
			opAdd: begin
				aluFunc   = aluAdd;
				setsFlags = 1'b1;
				writesRd  = 1'b1;
			end
			opSub: begin
				aluFunc   = aluSub;
				setsFlags = 1'b1;
				writesRd  = 1'b1;
			end
			opAnd: begin
				aluFunc   = aluAnd;
				setsFlags = 1'b1;
				writesRd  = 1'b1;
			end
			opOr: begin
				aluFunc   = aluOr;
				setsFlags = 1'b1;
				writesRd  = 1'b1;
			end
			opXor: begin
				aluFunc   = aluXor;
				setsFlags = 1'b1;
				writesRd  = 1'b1;
			end
			opAddi: begin
				op2Sel    = op2ImmShort;
				setsFlags = 1'b1;
				writesRd  = 1'b1;
			end
			opLdi: begin
				aluFunc  = aluPassB;
				op2Sel   = op2ImmLong;
				writesRd = 1'b1;
			end
			opLdw, opStw:      op2Sel = op2ImmShort; // Ra + offset
			opBr, opBeq, opBl: op2Sel = op2ImmLong;  // PC + offset
			opRet, opHalt:     ;
			default:           legalOp = 1'b0;
		endcase
	end

	assign isLoad   = (opcode == opLdw);
	assign isStore  = (opcode == opStw);
	assign isJump   = opcode inside {opBr, opBeq, opBl, opRet};
	assign takeJump = isJump && ((opcode != opBeq) || status.flags.zero);

	assign memDone  = memReq && memAck;
	assign memStart = ((state == stFetch) || (state == stMemory)) && !memReq && !memAck;

	assign halted = (state == stHalted);

	always_comb begin
		nextState = state;
		case (state)
			stFetch:  if (memDone) nextState = stDecode;
			stDecode: begin
				if ((opcode == opHalt) || !legalOp) nextState = stHalted;
				else nextState = stExecute;
			end
			stExecute: begin
				if (isLoad || isStore) nextState = stMemory;
				else if (isJump) nextState = stFetch;
				else nextState = stWriteback;
			end
			stMemory:    if (memDone) nextState = isLoad ? stWriteback : stFetch;
			stWriteback: nextState = stFetch;
			stHalted:    nextState = stHalted;
			default:     nextState = stFetch;
		endcase
	end

	always_comb begin
		ctrl.busSel   = busMem;
		ctrl.pcSel    = pcInc;
		ctrl.op1Sel   = op1Rd1;
		ctrl.op2Sel   = op2Sel;
		ctrl.rwSel    = rwRd;
		ctrl.wdSel    = wdBus;
		ctrl.aluFunc  = aluFunc;
		ctrl.pcWe     = 1'b0;
		ctrl.irWe     = 1'b0;
		ctrl.lrWe     = 1'b0;
		ctrl.aluOutWe = 1'b0;
		ctrl.regWe    = 1'b0;
		ctrl.flagsWe  = 1'b0;
		case (state)
			stFetch: begin
				ctrl.op1Sel = op1Pc; // address from PC
				ctrl.irWe   = memDone;
				ctrl.pcWe   = memDone;
			end
			stExecute: begin
				ctrl.busSel   = busAluOut; // port 2 stays on Rb outside memory steps
				ctrl.rwSel    = rwRa;
				ctrl.op1Sel   = isJump ? op1Pc : op1Rd1;
				ctrl.pcSel    = (opcode == opRet) ? pcLr : pcAlu;
				ctrl.pcWe     = takeJump;
				ctrl.lrWe     = (opcode == opBl);
				ctrl.aluOutWe = !isJump;
				ctrl.flagsWe  = setsFlags;
			end
			stMemory: begin
				// read data only valid while ack is high
				ctrl.regWe = isLoad && memDone;
			end
			stWriteback: begin
				ctrl.busSel = busAluOut;
				ctrl.regWe  = writesRd;
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			state  <= stFetch;
			memReq <= 1'b0;
			memWe  <= 1'b0;
		end else begin
			state <= nextState;
			if (memStart) begin
				memReq <= 1'b1;
				memWe  <= isStore && (state == stMemory);
			end else if (memDone) begin
				memReq <= 1'b0; // drop on the edge after ack
				memWe  <= 1'b0;
			end
		end
	end

endmodule

//--- src/cpuTop.sv
// processor top level joining controller, datapath and the memory port
`timescale 1ns/10ps

module cpuTop import cpuPkg::*; (
	input  logic Clock,
	input  logic reset,
	output logic memReq,
	input  logic memAck,
	output logic memWe,
	output wordT memAddr,
	output wordT memWData,
	input  wordT memRData,
	output logic halted
);

	dpCtrlT   ctrl;
	dpStatusT status;
	memReqT   reqData;
	logic     ctrlMemWe;

	controller i_controller (
		.Clock  (Clock),
		.reset  (reset),
		.status (status),
		.memAck (memAck),
		.ctrl   (ctrl),
		.memReq (memReq),
		.memWe  (ctrlMemWe),
		.halted (halted)
	);

	datapath i_datapath (
		.Clock      (Clock),
		.reset      (reset),
		.ctrl       (ctrl),
		.memRData   (memRData),
		.status     (status),
		.memReqData (reqData)
	);

	assign memAddr   = reqData.addr;
	assign memWData  = reqData.wdata;
	assign memWe     = ctrlMemWe & reqData.we; // both agree only during a store request

endmodule

//--- verif/cpuTop_props.sv
// handshake assertions for the processor memory port, bound into cpuTop
`timescale 1ns/10ps

module cpuTop_props import cpuPkg::*; (
	input logic Clock,
	input logic reset,
	input logic memReq,
	input logic memAck,
	input logic memWe,
	input wordT memAddr,
	input wordT memWData,
	input logic halted
);

	// request held until the memory answers
	reqHeld: assert property (@(posedge Clock) disable iff (reset)
		memReq && !memAck |=> memReq)
		else $error("memReq fell before memAck was seen");

	reqStable: assert property (@(posedge Clock) disable iff (reset)
		memReq && $past(memReq) |-> $stable({memWe, memAddr, memWData}))
		else $error("request contents changed while memReq was high");

	// new request only once the previous ack is gone
	noRiseOnAck: assert property (@(posedge Clock) disable iff (reset)
		$rose(memReq) |-> !$past(memAck))
		else $error("memReq rose while memAck was high");

	resetQuiet: assert property (@(posedge Clock)
		reset |=> !memReq && !halted)
		else $error("memReq or halted high right after reset");

endmodule

//--- verif/tbCpu.sv
// CPU testbench with clock, reset, memory model, directed tests, compare tasks and timeout
`timescale 1ns/10ps

module tbCpu import cpuPkg::*; ();

	localparam int resetCycles   = 16;
	localparam int timeoutCycles = 6 * 40 * 12; // tests x instructions x cycles per instruction

	logic Clock = 1'b0;
	logic reset = 1'b1;
	logic memAck = 1'b0;
	wordT memRData = '0;
	logic memReq;
	logic memWe;
	wordT memAddr;
	wordT memWData;
	logic halted;

	wordT   image [256]; // program and data image copied into mem during reset
	wordT   mem [256];
	int     delays [64];
	memReqT stores [$];  // writes seen at the port
	memReqT req;
	int     waitLeft;
	int     reqCount;
	int     progPtr;
	int     cycleCount = 0;
	int     errorCount = 0;
	int     checkCount = 0;
	int     testCount = 0;

	cpuTop i_cpuTop (
		.Clock    (Clock),
		.reset    (reset),
		.memReq   (memReq),
		.memAck   (memAck),
		.memWe    (memWe),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRData (memRData),
		.halted   (halted)
	);

	bind cpuTop cpuTop_props i_props (
		.Clock    (Clock),
		.reset    (reset),
		.memReq   (memReq),
		.memAck   (memAck),
		.memWe    (memWe),
		.memAddr  (memAddr),
		.memWData (memWData),
		.halted   (halted)
	);

	always #5 Clock = ~Clock;

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > timeoutCycles) begin
			$display("Timeout: the processor did not halt within %0d cycles", timeoutCycles);
			$display("Something failed");
			$finish;
		end
	end

	// four-phase memory with ack after a table driven delay
	always @(negedge Clock) begin
		if (reset) begin
			mem = image;
			stores.delete();
			memAck = 1'b0;
			waitLeft = -1;
			reqCount = 0;
		end else if (memAck) begin
			if (!memReq) memAck = 1'b0; // request withdrawn
		end else if (memReq) begin
			if (waitLeft < 0) begin
				waitLeft = delays[reqCount[5:0]];
				reqCount++;
			end
			if (waitLeft == 0) begin
				if (memWe) begin
					mem[memAddr[7:0]] = memWData;
					req.we = 1'b1;
					req.addr = memAddr;
					req.wdata = memWData;
					stores.push_back(req);
				end else begin
					memRData = mem[memAddr[7:0]];
				end
				memAck = 1'b1;
				waitLeft = -1;
			end else begin
				waitLeft--;
			end
		end
	end

	function automatic wordT regForm(opcodeT op, logic [2:0] rd, logic [2:0] ra, logic [2:0] rb);
		return {op, rd, ra, rb, 2'b00};
	endfunction

	function automatic wordT shortForm(opcodeT op, logic [2:0] rd, logic [2:0] ra, logic [4:0] imm);
		return {op, rd, ra, imm};
	endfunction

	function automatic wordT longForm(opcodeT op, logic [2:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic wordT sext8(logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic wordT sext5(logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	task automatic clearImage();
		for (int a = 0; a < 256; a++) begin
			image[a[7:0]] = {a[7:0] ^ 8'hc7, a[7:0]};
		end
		progPtr = 0;
	endtask

	task automatic emit(wordT w);
		image[progPtr[7:0]] = w;
		progPtr++;
	endtask

	task automatic setDelays(int maxDelay);
		for (int i = 0; i < 64; i++) begin
			delays[i[5:0]] = (maxDelay == 0) ? 0 : $urandom_range(maxDelay, 0);
		end
	endtask

	task automatic compareWord(string what, wordT got, wordT exp);
		checkCount++;
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic compareReq(string what, memReqT got, memReqT exp);
		checkCount++;
		if (got !== exp) begin
			$display("ERROR at %0t: %s is we %b addr %h data %h, expected we %b addr %h data %h",
				$time, what, got.we, got.addr, got.wdata, exp.we, exp.addr, exp.wdata);
			errorCount++;
		end
	endtask

	// port transaction plus the word left in memory
	task automatic checkStore(int idx, wordT addr, wordT data);
		memReqT exp;
		exp.we = 1'b1;
		exp.addr = addr;
		exp.wdata = data;
		if (idx >= stores.size()) begin
			$display("Store %0d never reached the memory port", idx);
			errorCount++;
		end else begin
			compareReq($sformatf("store %0d", idx), stores[idx], exp);
		end
		compareWord($sformatf("memory word %h", addr), mem[addr[7:0]], data);
	endtask

	task automatic runProgram();
		@(negedge Clock);
		reset = 1'b1;
		repeat (resetCycles) begin
			@(negedge Clock);
			if (memReq) begin
				$display("ERROR at %0t: memReq is high while reset is held", $time);
				errorCount++;
			end
		end
		reset = 1'b0;
		while (!memReq) @(negedge Clock);
		compareWord("first fetch address", memAddr, resetPc);
		while (!halted) @(negedge Clock);
	endtask

	task automatic endTest(string name, int errBefore);
		testCount++;
		if (errorCount == errBefore) $display("%s: passed", name);
		else $display("%s: failed with %0d errors", name, errorCount - errBefore);
	endtask

	// operands in r1, r2 and r4 with every result in r3
	task automatic aluOps();
		wordT a;
		wordT b;
		wordT c;
		int   errBefore;
		errBefore = errorCount;
		a = sext8(8'h7b);
		b = sext8(8'hf6);
		c = sext8(8'hc3);
		clearImage();
		emit(longForm(opLdi, 3'd7, 8'h60));
		emit(longForm(opLdi, 3'd1, 8'h7b));
		emit(longForm(opLdi, 3'd2, 8'hf6));
		emit(longForm(opLdi, 3'd4, 8'hc3));
		emit(regForm(opAdd, 3'd3, 3'd1, 3'd2));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd0));
		emit(regForm(opSub, 3'd3, 3'd1, 3'd2));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd1));
		emit(regForm(opAnd, 3'd3, 3'd1, 3'd4));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd2));
		emit(regForm(opOr, 3'd3, 3'd1, 3'd4));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd3));
		emit(regForm(opXor, 3'd3, 3'd1, 3'd4));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd4));
		emit(longForm(opHalt, 3'd0, 8'h00));
		setDelays(3);
		runProgram();
		compareWord("store count", wordT'(stores.size()), 16'd5);
		checkStore(0, 16'h0060, a + b);
		checkStore(1, 16'h0061, a - b);
		checkStore(2, 16'h0062, a & c);
		checkStore(3, 16'h0063, a | c);
		checkStore(4, 16'h0064, a ^ c);
		endTest("arithmetic and logic", errBefore);
	endtask

	task automatic loadStore();
		int errBefore;
		errBefore = errorCount;
		clearImage();
		image[8'h50] = 16'h1234;
		image[8'h53] = 16'hbeef;
		emit(longForm(opLdi, 3'd1, 8'h50));
		emit(longForm(opLdi, 3'd7, 8'h60));
		emit(shortForm(opLdw, 3'd2, 3'd1, 5'd0));
		emit(shortForm(opLdw, 3'd3, 3'd1, 5'd3));
		emit(shortForm(opStw, 3'd2, 3'd7, 5'd4));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'h1f)); // negative offset
		emit(longForm(opHalt, 3'd0, 8'h00));
		setDelays(3);
		runProgram();
		compareWord("store count", wordT'(stores.size()), 16'd2);
		checkStore(0, 16'h0060 + sext5(5'd4), 16'h1234);
		checkStore(1, 16'h0060 + sext5(5'h1f), 16'hbeef);
		endTest("load and store", errBefore);
	endtask

	task automatic branchCond();
		int errBefore;
		errBefore = errorCount;
		clearImage();
		emit(longForm(opLdi, 3'd7, 8'h60));
		emit(longForm(opLdi, 3'd1, 8'h25));
		emit(longForm(opLdi, 3'd2, 8'h25));
		emit(regForm(opSub, 3'd5, 3'd1, 3'd2)); // zero
		emit(longForm(opBeq, 3'd0, 8'd2));
		emit(longForm(opLdi, 3'd3, 8'h11));    // skipped marker
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd0));
		emit(longForm(opLdi, 3'd3, 8'h22));
		emit(shortForm(opStw, 3'd3, 3'd7, 5'd0));
		emit(longForm(opLdi, 3'd2, 8'h24));
		emit(regForm(opSub, 3'd5, 3'd1, 3'd2)); // nonzero
		emit(longForm(opBeq, 3'd0, 8'd2));
		emit(longForm(opLdi, 3'd4, 8'h33));
		emit(shortForm(opStw, 3'd4, 3'd7, 5'd1));
		emit(longForm(opHalt, 3'd0, 8'h00));
		setDelays(3);
		runProgram();
		compareWord("store count", wordT'(stores.size()), 16'd2);
		checkStore(0, 16'h0060, sext8(8'h22));
		checkStore(1, 16'h0061, sext8(8'h33));
		endTest("conditional branch", errBefore);
	endtask

	task automatic subroutineCall();
		int errBefore;
		errBefore = errorCount;
		clearImage();
		emit(longForm(opLdi, 3'd7, 8'h60));
		emit(longForm(opBl, 3'd0, 8'd5));
		emit(longForm(opLdi, 3'd2, 8'h5b));     // after return
		emit(shortForm(opStw, 3'd2, 3'd7, 5'd1));
		emit(longForm(opBr, 3'd0, 8'd1));
		emit(shortForm(opStw, 3'd7, 3'd7, 5'd2));
		emit(longForm(opHalt, 3'd0, 8'h00));
		emit(longForm(opLdi, 3'd1, 8'h4a));     // subroutine body
		emit(shortForm(opStw, 3'd1, 3'd7, 5'd0));
		emit(longForm(opRet, 3'd0, 8'h00));
		setDelays(3);
		runProgram();
		compareWord("store count", wordT'(stores.size()), 16'd2);
		checkStore(0, 16'h0060, sext8(8'h4a));
		checkStore(1, 16'h0061, sext8(8'h5b));
		endTest("subroutine", errBefore);
	endtask

	task automatic backPressure();
		memReqT baseline [$];
		wordT   sum;
		int     errBefore;
		errBefore = errorCount;
		clearImage();
		emit(longForm(opLdi, 3'd7, 8'h60));
		emit(longForm(opLdi, 3'd1, 8'h05));
		emit(longForm(opLdi, 3'd2, 8'h00));
		emit(regForm(opAdd, 3'd2, 3'd1, 3'd2)); // loop top
		emit(shortForm(opStw, 3'd2, 3'd7, 5'd0));
		emit(shortForm(opAddi, 3'd7, 3'd7, 5'd1));
		emit(shortForm(opAddi, 3'd1, 3'd1, 5'h1f)); // count down
		emit(longForm(opBeq, 3'd0, 8'd1));
		emit(longForm(opBr, 3'd0, 8'hfa));
		emit(longForm(opHalt, 3'd0, 8'h00));
		setDelays(0);
		runProgram();
		baseline = stores;
		sum = '0;
		compareWord("zero delay store count", wordT'(stores.size()), 16'd5);
		for (int n = 5; n > 0; n--) begin
			sum = sum + wordT'(n);
			checkStore(5 - n, 16'h0060 + wordT'(5 - n), sum);
		end
		setDelays(3);
		runProgram();
		compareWord("delayed store count", wordT'(stores.size()), wordT'(baseline.size()));
		for (int i = 0; i < baseline.size() && i < stores.size(); i++) begin
			compareReq($sformatf("delayed store %0d", i), stores[i], baseline[i]);
		end
		endTest("back-pressure and reset", errBefore);
	endtask

	initial begin
		void'($urandom(32'hb6e5));
		aluOps();
		loadStore();
		branchCond();
		subroutineCall();
		backPressure();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- list.f
src/cpuPkg.sv
src/regBlock.sv
src/alu.sv
src/datapath.sv
src/controller.sv
src/cpuTop.sv
verif/cpuTop_props.sv
verif/tbCpu.sv

//--- Makefile
# Verilator build and run for the multicycle CPU testbench

VERILATOR ?= verilator
TOP       ?= tbCpu
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard src/*.sv verif/*.sv)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
